//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cache_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "SIMULATION PASSED" $(LOG); then \
		echo "test: pass"; \
	else \
		echo "test: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- source/cache_array.sv
// ====================
// cache storage array
// one write port, registered read port
// payload set by a type parameter
// ====================
`timescale 1ns/1ps

module cache_array #(
    parameter type entry_t = logic [15:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    // storage, no reset on the payload
    entry_t mem [DEPTH];

    // read sees the old value on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

//--- source/cache_ctrl.sv
// ====================
// cache control
// processor handshake, tag compare, hit return
// miss hand-off to the fill engine and replay
// tag sweep to invalid after reset
// ====================
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               rd_valid,
    input  logic [cache_pkg::ADDR_W-1:0]                       rd_addr,
    output logic                                               rd_ready,
    output logic                                               rd_data_valid,
    output mem_pkg::word_t                                     rd_data,
    output logic [cache_pkg::INDEX_W-1:0]                      tag_raddr,
    input  cache_pkg::tag_entry_t                              tag_rdata,
    output logic [cache_pkg::INDEX_W+cache_pkg::OFFSET_W-1:0]  data_raddr,
    input  mem_pkg::word_t                                     data_rdata,
    output logic [cache_pkg::INDEX_W+cache_pkg::OFFSET_W-1:0]  data_waddr,
    output logic                                               tag_init_we,
    output logic                                               miss_detected,
    output logic [cache_pkg::ADDR_W-1:0]                       miss_address,
    input  logic                                               fill_busy,
    input  logic                                               tag_we,
    input  logic [cache_pkg::OFFSET_W-1:0]                     fill_offset
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_LOOKUP,
        ST_COMPARE,
        ST_WAIT_FILL,
        ST_RESP
    } state_t;

    state_t              state;
    logic [ADDR_W-1:0]   addr_q;
    logic [INDEX_W-1:0]  sweep_idx;
    logic [INDEX_W-1:0]  req_index;
    logic                hit;

    assign req_index = addr_q[INDEX_LSB +: INDEX_W];

    // sweep borrows the tag address, the shared write port uses it too
    assign tag_raddr   = (state == ST_SWEEP) ? sweep_idx : req_index;
    assign tag_init_we = (state == ST_SWEEP);
    assign data_raddr  = {req_index, addr_q[OFFSET_LSB +: OFFSET_W]};
    // fill writes land in the line of the held address
    assign data_waddr  = {req_index, fill_offset};

    // tag read is one cycle old in COMPARE
    assign hit = tag_rdata.valid && (tag_rdata.tag == addr_q[TAG_LSB +: TAG_W]);

    // hand off only to an idle fill engine
    assign miss_detected = (state == ST_COMPARE) && !hit && !fill_busy;
    assign miss_address  = addr_q;

    assign rd_ready      = (state == ST_IDLE) && !fill_busy;
    assign rd_data_valid = (state == ST_RESP);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_SWEEP;
            sweep_idx <= '0;
        end else begin
            case (state)
                ST_SWEEP: begin
                    sweep_idx <= sweep_idx + INDEX_W'(1);
                    if (sweep_idx == INDEX_W'(NUM_LINES - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (rd_valid && rd_ready) begin
                        state <= ST_LOOKUP;
                    end
                end
                // arrays register the read here
                ST_LOOKUP: state <= ST_COMPARE;
                ST_COMPARE: begin
                    if (hit) begin
                        state <= ST_RESP;
                    end else if (miss_detected) begin
                        state <= ST_WAIT_FILL;
                    end
                end
                // replay once the tag is in
                ST_WAIT_FILL: begin
                    if (tag_we) begin
                        state <= ST_LOOKUP;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // held address and returned word
    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) begin
            addr_q <= rd_addr;
        end
        if ((state == ST_COMPARE) && hit) begin
            rd_data <= data_rdata;
        end
    end

endmodule

//--- source/cache_fill_fsm.sv
// ====================
// cache miss fill engine
// pipelined block fetch under credit flow control
// separate request and receive counters
// tag written with the last returned word
// ====================
`timescale 1ns/1ps

module cache_fill_fsm #(
    parameter int MEM_CREDITS = mem_pkg::DEFAULT_CREDITS
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            miss_detected,
    input  logic [cache_pkg::ADDR_W-1:0]    miss_address,
    input  logic                            mem_rsp_valid,
    input  logic                            mem_credit,
    output logic                            fill_busy,
    output logic                            mem_req_valid,
    output logic [cache_pkg::ADDR_W-1:0]    mem_req_addr,
    output logic                            data_we,
    output logic [cache_pkg::OFFSET_W-1:0]  fill_offset,
    output logic                            tag_we,
    output cache_pkg::tag_entry_t           tag_wdata
);
    import cache_pkg::*;
    import mem_pkg::*;

    // credit counter must hold the full count
    localparam int CREDIT_W = $clog2(MEM_CREDITS + 1);
    // one extra bit so the request count can stop at BLOCK_WORDS
    localparam int REQ_W = $clog2(BLOCK_WORDS) + 1;

    logic                busy;
    logic [REQ_W-1:0]    req_cnt;
    logic [OFFSET_W-1:0] rcv_cnt;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                req_done;
    logic                last_word;

    // all requests of the block sent
    assign req_done = (req_cnt == REQ_W'(BLOCK_WORDS));

    // one request per cycle while a slot is free
    assign mem_req_valid = busy && !req_done && (credit_cnt != '0);

    // block base from the miss, word from the request count
    assign mem_req_addr = {miss_address[ADDR_W-1:INDEX_LSB],
                           req_cnt[OFFSET_W-1:0],
                           {OFFSET_LSB{1'b0}}};

    // every returned word goes straight into the data array
    assign data_we     = busy && mem_rsp_valid;
    assign fill_offset = rcv_cnt;
    assign last_word   = (rcv_cnt == OFFSET_W'(BLOCK_WORDS - 1));

    // tag and valid go in with the eighth word
    assign tag_we    = data_we && last_word;
    assign fill_busy = busy;

    always_comb begin
        tag_wdata.valid = 1'b1;
        tag_wdata.tag   = miss_address[TAG_LSB +: TAG_W];
    end

    // busy state and the two counters
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            req_cnt <= '0;
            rcv_cnt <= '0;
        end else if (!busy) begin
            if (miss_detected) begin
                busy    <= 1'b1;
                req_cnt <= '0;
                rcv_cnt <= '0;
            end
        end else begin
            // request side runs ahead of the responses
            if (mem_req_valid) begin
                req_cnt <= req_cnt + REQ_W'(1);
            end
            if (data_we) begin
                rcv_cnt <= rcv_cnt + OFFSET_W'(1);
            end
            if (tag_we) begin
                busy <= 1'b0;
            end
        end
    end

    // spend on request, refill on returned credit, both may hit one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CREDIT_W'(MEM_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CREDIT_W'(mem_credit) - CREDIT_W'(mem_req_valid);
        end
    end

endmodule

//--- source/cache_pkg.sv
// ====================
// cache geometry package
// address split, line count and the
// layout of one tag store entry
// ====================
package cache_pkg;

    // processor byte address
    localparam int ADDR_W = 16;

    // direct mapped, one block per line
    localparam int NUM_LINES = 16;

    // field widths of the address
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 8;

    // field positions, bit 0 selects the byte within a word
    localparam int OFFSET_LSB = 1;
    localparam int INDEX_LSB  = OFFSET_LSB + OFFSET_W;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_W;

    // one tag store entry, valid bit on top
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

//--- source/cache_top.sv
// ====================
// read-only direct-mapped cache
// control, fill engine, tag and data stores
// ====================
`timescale 1ns/1ps

module cache_top #(
    parameter int MEM_CREDITS = mem_pkg::DEFAULT_CREDITS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_valid,
    input  logic [cache_pkg::ADDR_W-1:0]  rd_addr,
    output logic                          rd_ready,
    output logic                          rd_data_valid,
    output mem_pkg::word_t                rd_data,
    output logic                          mem_req_valid,
    output logic [cache_pkg::ADDR_W-1:0]  mem_req_addr,
    input  logic                          mem_credit,
    input  logic                          mem_rsp_valid,
    input  mem_pkg::word_t                mem_rsp_data
);
    import cache_pkg::*;
    import mem_pkg::*;

    // data store holds every word of every line
    localparam int DATA_AW = INDEX_W + OFFSET_W;

    logic [INDEX_W-1:0]  tag_raddr;
    tag_entry_t          tag_rdata;
    tag_entry_t          tag_wdata_fill;
    tag_entry_t          tag_wdata;
    logic                tag_init_we;
    logic                tag_we;
    logic                tag_wr;
    logic [DATA_AW-1:0]  data_raddr;
    logic [DATA_AW-1:0]  data_waddr;
    word_t               data_rdata;
    logic                data_we;
    logic [OFFSET_W-1:0] fill_offset;
    logic                miss_detected;
    logic [ADDR_W-1:0]   miss_address;
    logic                fill_busy;

    // sweep writes an all-zero entry, which is invalid
    assign tag_wr    = tag_we | tag_init_we;
    assign tag_wdata = tag_init_we ? '0 : tag_wdata_fill;

    cache_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .rd_ready      (rd_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .tag_raddr     (tag_raddr),
        .tag_rdata     (tag_rdata),
        .data_raddr    (data_raddr),
        .data_rdata    (data_rdata),
        .data_waddr    (data_waddr),
        .tag_init_we   (tag_init_we),
        .miss_detected (miss_detected),
        .miss_address  (miss_address),
        .fill_busy     (fill_busy),
        .tag_we        (tag_we),
        .fill_offset   (fill_offset)
    );

    cache_fill_fsm #(
        .MEM_CREDITS (MEM_CREDITS)
    ) i_fill (
        .clk           (clk),
        .rst           (rst),
        .miss_detected (miss_detected),
        .miss_address  (miss_address),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_credit    (mem_credit),
        .fill_busy     (fill_busy),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .data_we       (data_we),
        .fill_offset   (fill_offset),
        .tag_we        (tag_we),
        .tag_wdata     (tag_wdata_fill)
    );

    // tag write address is the lookup index, or the sweep index during sweep
    cache_array #(
        .entry_t (tag_entry_t),
        .DEPTH   (NUM_LINES)
    ) tag_store (
        .clk   (clk),
        .we    (tag_wr),
        .waddr (tag_raddr),
        .wdata (tag_wdata),
        .raddr (tag_raddr),
        .rdata (tag_rdata)
    );

    // memory words go in unchanged
    cache_array #(
        .entry_t (word_t),
        .DEPTH   (NUM_LINES * BLOCK_WORDS)
    ) data_store (
        .clk   (clk),
        .we    (data_we),
        .waddr (data_waddr),
        .wdata (mem_rsp_data),
        .raddr (data_raddr),
        .rdata (data_rdata)
    );

endmodule

//--- source/mem_pkg.sv
// ====================
// memory bus package
// data word, block size and request slots
// ====================
package mem_pkg;

    // width of one data word on the memory bus
    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;

    // a fill moves one whole block
    localparam int BLOCK_WORDS = 8;

    // request slots the memory offers after reset
    localparam int DEFAULT_CREDITS = 4;

endpackage

//--- src.f
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_array.sv
source/cache_fill_fsm.sv
source/cache_ctrl.sv
source/cache_top.sv
verification/tb_clock.sv
verification/cache_checker.sv
verification/cache_props.sv
verification/cache_tb.sv

//--- verification/cache_checker.sv
// ====================
// cache read checker
// shadow tag per line decides hit or miss
// compares read data, fill request addresses,
// hit latency and outstanding credits
// ====================
`timescale 1ns/1ps

module cache_checker #(
    parameter int             MEM_CREDITS = 4,
    parameter mem_pkg::word_t MEM_PATTERN = 16'h5a3c
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rd_valid,
    input  logic [cache_pkg::ADDR_W-1:0] rd_addr,
    input  logic                         rd_ready,
    input  logic                         rd_data_valid,
    input  mem_pkg::word_t               rd_data,
    input  logic                         mem_req_valid,
    input  logic [cache_pkg::ADDR_W-1:0] mem_req_addr,
    input  logic                         mem_credit,
    output int                           mismatch_count,
    output int                           protocol_count,
    output int                           reads_checked
);
    import cache_pkg::*;
    import mem_pkg::*;

    // accept edge, then lookup, compare and the response cycle
    localparam int HIT_LATENCY = 3;

    logic              sh_valid [NUM_LINES];
    logic [TAG_W-1:0]  sh_tag   [NUM_LINES];
    // block addresses still owed by the current fill
    logic [ADDR_W-1:0] exp_req  [$];
    logic [ADDR_W-1:0] cur_addr;
    word_t             exp_data;
    logic              exp_miss;
    logic              pending;
    logic              any_accept;
    logic              ready_seen;
    int                edge_cnt;
    int                accept_edge;
    int                since_reset;
    int                outstanding;

    // memory word: word address xor a fixed pattern
    function automatic word_t ref_word(input logic [ADDR_W-1:0] addr);
        return {1'b0, addr[ADDR_W-1:1]} ^ MEM_PATTERN;
    endfunction

    task automatic start_read(input logic [ADDR_W-1:0] addr);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        idx = addr[7:4];
        tg  = addr[15:8];
        if (pending) begin
            protocol_count++;
            $display("error at %0t: read of %h accepted while a read is open", $time, addr);
        end
        exp_miss = !(sh_valid[idx] && (sh_tag[idx] == tg));
        exp_data = ref_word(addr);
        // a miss fetches the whole block, word 0 first
        if (exp_miss) begin
            for (int o = 0; o < BLOCK_WORDS; o++) begin
                exp_req.push_back({addr[15:4], o[2:0], 1'b0});
            end
            sh_valid[idx] = 1'b1;
            sh_tag[idx]   = tg;
        end
        cur_addr    = addr;
        accept_edge = edge_cnt;
        pending     = 1'b1;
        any_accept  = 1'b1;
    endtask

    task automatic check_request(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] want;
        outstanding++;
        if (exp_req.size() == 0) begin
            protocol_count++;
            $display("error at %0t: memory request %h with no fill expected", $time, addr);
        end else begin
            want = exp_req.pop_front();
            if (addr !== want) begin
                mismatch_count++;
                $display("mismatch at %0t: mem_req_addr %h, expected %h", $time, addr, want);
            end
        end
    endtask

    task automatic check_response();
        if (!pending) begin
            protocol_count++;
            $display("error at %0t: read data returned with no read open", $time);
        end else begin
            if (exp_req.size() != 0) begin
                protocol_count++;
                $display("error at %0t: read of %h done with %0d fill requests missing",
                         $time, cur_addr, exp_req.size());
                exp_req.delete();
            end
            if (rd_data !== exp_data) begin
                mismatch_count++;
                $display("mismatch at %0t: rd_data for %h is %h, expected %h",
                         $time, cur_addr, rd_data, exp_data);
            end
            if (!exp_miss && (edge_cnt - accept_edge != HIT_LATENCY)) begin
                mismatch_count++;
                $display("mismatch at %0t: hit latency for %h is %0d, expected %0d",
                         $time, cur_addr, edge_cnt - accept_edge, HIT_LATENCY);
            end
            reads_checked++;
            pending = 1'b0;
        end
    endtask

    // tag sweep holds rd_ready low, nothing moves before the first read
    task automatic check_startup();
        if (!ready_seen) begin
            if (rd_ready) begin
                ready_seen = 1'b1;
                if (since_reset < NUM_LINES) begin
                    protocol_count++;
                    $display("error at %0t: rd_ready high %0d cycles after reset, sweep cut short",
                             $time, since_reset);
                end
            end else begin
                since_reset++;
            end
        end
        if (!any_accept && (mem_req_valid || rd_data_valid)) begin
            protocol_count++;
            $display("error at %0t: memory request or read data before the first read", $time);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            sh_valid    = '{default: 1'b0};
            exp_req.delete();
            pending     = 1'b0;
            any_accept  = 1'b0;
            ready_seen  = 1'b0;
            edge_cnt    = 0;
            since_reset = 0;
            outstanding = 0;
        end else begin
            check_startup();
            if (rd_valid && rd_ready) begin
                start_read(rd_addr);
            end
            if (mem_req_valid) begin
                check_request(mem_req_addr);
            end
            if (mem_credit) begin
                outstanding--;
            end
            if (outstanding > MEM_CREDITS) begin
                protocol_count++;
                $display("error at %0t: %0d requests in flight, only %0d credits",
                         $time, outstanding, MEM_CREDITS);
            end
            if (rd_data_valid) begin
                check_response();
            end
            edge_cnt++;
        end
    end

endmodule

//--- verification/cache_props.sv
// ====================
// fill engine assertions
// credit bounds and fill write enables
// ====================
`timescale 1ns/1ps

module cache_props #(
    parameter int MEM_CREDITS = 4
) (
    input logic                             clk,
    input logic                             rst,
    input logic                             fill_busy,
    input logic                             mem_req_valid,
    input logic                             mem_credit,
    input logic                             mem_rsp_valid,
    input logic                             req_done,
    input logic                             tag_we,
    input logic [$clog2(MEM_CREDITS+1)-1:0] credit_cnt
);

    // count never climbs above the slots the memory offers
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        int'(credit_cnt) <= MEM_CREDITS)
        else $error("credit count above the number of memory slots");

    // a lone returned credit needs room in the counter
    a_credit_room: assert property (@(posedge clk) disable iff (rst)
        (mem_credit && !mem_req_valid) |-> (int'(credit_cnt) < MEM_CREDITS))
        else $error("credit returned while the counter was full");

    // every returned word finds a fill to land in
    a_rsp_in_fill: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> fill_busy)
        else $error("memory word returned outside a fill");

    // last word and tag only once the whole block was requested
    a_tag_after_requests: assert property (@(posedge clk) disable iff (rst)
        tag_we |-> req_done)
        else $error("tag written before all block requests were sent");

endmodule

bind cache_fill_fsm cache_props #(
    .MEM_CREDITS (MEM_CREDITS)
) i_props (
    .clk           (clk),
    .rst           (rst),
    .fill_busy     (fill_busy),
    .mem_req_valid (mem_req_valid),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .req_done      (req_done),
    .tag_we        (tag_we),
    .credit_cnt    (credit_cnt)
);

//--- verification/cache_tb.sv
// ====================
// cache testbench
// drives processor reads, plays the memory
// with in-order responses and credit return,
// bounds the run and prints the result
// ====================
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int          MEM_CREDITS  = DEFAULT_CREDITS;
    localparam word_t       MEM_PATTERN  = 16'h5a3c;
    localparam logic [31:0] SEED         = 32'ha8b91a4e;
    localparam int          RESET_CYCLES = 2;
    localparam int          RANDOM_READS = 200;
    // cold miss, hits, slow credits, eviction, random mix
    localparam int NUM_READS      = 1 + 3 + 2 + 3 + RANDOM_READS;
    localparam int TIMEOUT_CYCLES = NUM_READS * 60 + NUM_LINES + RESET_CYCLES;

    logic              clk;
    logic              rst;
    logic              rd_valid;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_ready;
    logic              rd_data_valid;
    word_t             rd_data;
    logic              mem_req_valid;
    logic [ADDR_W-1:0] mem_req_addr;
    logic              mem_credit    = 1'b0;
    logic              mem_rsp_valid = 1'b0;
    word_t             mem_rsp_data  = '0;

    int mismatch_count;
    int protocol_count;
    int reads_checked;
    int tb_errors;
    int cycle;
    // credit return delay range, widened for the slow phase
    int credit_min = 1;
    int credit_max = 3;
    // set once the closing verdict has gone out
    logic verdict_printed = 1'b0;

    // memory side bookkeeping, one entry per request in flight
    logic [ADDR_W-1:0] req_addr_q [$];
    int                req_due_q  [$];
    int                credit_due_q [$];
    int                last_due;

    tb_clock #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock (
        .clk (clk),
        .rst (rst)
    );

    cache_top #(
        .MEM_CREDITS (MEM_CREDITS)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .rd_ready      (rd_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    cache_checker #(
        .MEM_CREDITS (MEM_CREDITS),
        .MEM_PATTERN (MEM_PATTERN)
    ) i_checker (
        .clk            (clk),
        .rst            (rst),
        .rd_valid       (rd_valid),
        .rd_addr        (rd_addr),
        .rd_ready       (rd_ready),
        .rd_data_valid  (rd_data_valid),
        .rd_data        (rd_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_credit     (mem_credit),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .reads_checked  (reads_checked)
    );

    // same word rule as the checker
    function automatic word_t mem_word(input logic [ADDR_W-1:0] addr);
        return {1'b0, addr[ADDR_W-1:1]} ^ MEM_PATTERN;
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // requests taken on the rising edge, answers driven on the falling edge
    always begin : memory_model
        int due;
        int wait_c;
        @(posedge clk);
        if (rst) begin
            req_addr_q.delete();
            req_due_q.delete();
            credit_due_q.delete();
            last_due = 0;
        end else if (mem_req_valid) begin
            due = cycle + 3 + int'($urandom % 32'd4);
            // keep answers in request order
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            req_addr_q.push_back(mem_req_addr);
            req_due_q.push_back(due);
        end
        @(negedge clk);
        mem_rsp_valid = 1'b0;
        mem_credit    = 1'b0;
        if (req_due_q.size() > 0 && req_due_q[0] <= cycle) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = mem_word(req_addr_q.pop_front());
            void'(req_due_q.pop_front());
            // slot frees a little after the word leaves
            wait_c = int'($urandom % 32'(credit_max - credit_min + 1));
            credit_due_q.push_back(cycle + credit_min + wait_c);
        end
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
            mem_credit = 1'b1;
            void'(credit_due_q.pop_front());
        end
    end

    // one processor read, back on a falling edge after the data pulse
    task automatic do_read(input logic [ADDR_W-1:0] addr);
        rd_valid = 1'b1;
        rd_addr  = addr;
        @(posedge clk);
        while (!rd_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        rd_valid = 1'b0;
        @(posedge clk);
        while (!rd_data_valid) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatch, %0d protocol, %0d testbench, %0d of %0d reads checked",
                 mismatch_count, protocol_count, tb_errors, reads_checked, NUM_READS);
    endtask

    task automatic finish_run();
        if (reads_checked != NUM_READS) begin
            tb_errors++;
            $display("error: only %0d of %0d reads were checked", reads_checked, NUM_READS);
        end
        verdict_printed = 1'b1;
        print_counts();
        if (mismatch_count + protocol_count + tb_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            verdict_printed = 1'b1;
            $display("timeout: reads still running after %0d cycles", cycle);
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // a failed assertion stops the run before the report
    final begin
        if (!verdict_printed) begin
            $display("run stopped early by a failed assertion");
            print_counts();
            $display("SIMULATION FAILED");
        end
    end

    initial begin : stimulus
        logic [ADDR_W-1:0] addr;
        void'($urandom(SEED));
        rd_valid = 1'b0;
        rd_addr  = '0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        // cold miss, whole block fetched
        do_read(16'h1234);
        // rest of the same block hits
        do_read(16'h1230);
        do_read(16'h123e);
        do_read(16'h1236);
        // slow credit return, requests stall on credits
        credit_min = 6;
        credit_max = 10;
        do_read(16'h2408);
        do_read(16'h240e);
        credit_min = 1;
        credit_max = 3;
        // index 5 with tags 34 and 55, each evicts the other
        do_read(16'h3456);
        do_read(16'h5552);
        do_read(16'h3456);
        // 1 KB range, four tags compete per index
        repeat (RANDOM_READS) begin
            addr = 16'($urandom) & 16'h03fe;
            do_read(addr);
        end
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

//--- verification/tb_clock.sv
// ====================
// testbench clock and reset
// free-running clock, reset over the first edges
// ====================
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released on a rising edge, the DUT still samples it high there
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
